//--- pcw_pkg.sv
/*
 * Shared definitions for the PCW system-control block.
 * Bus widths, I/O port addresses, F8 command codes, register structs,
 * reset values, clock-enable increments and display palette constants.
 */
package pcw_pkg;

    localparam int CPU_ADDR_W = 16;
    localparam int BYTE_W     = 8;
    localparam int RAM_ADDR_W = 21;
    localparam int PAGE_W     = 7;
    localparam int RGB_W      = 18;

    typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [PAGE_W-1:0]     page_t;
    typedef logic [RGB_W-1:0]      rgb_t;

    // One CPU bus cycle, flags active high
    typedef struct packed {
        cpu_addr_t addr;
        byte_t     wdata;
        logic      io_rd;
        logic      io_wr;
        logic      mem_wr;
    } cpu_bus_t;

    // Page bytes F0-F3 and the CPC read-lock byte F4
    typedef struct packed {
        byte_t f0;
        byte_t f1;
        byte_t f2;
        byte_t f3;
        byte_t f4;
    } page_regs_t;

    typedef struct packed {
        byte_t roller_ptr;
        byte_t yscroll;
        logic  inverse;
        logic  disable_vid;
    } video_ctrl_t;

    typedef struct packed {
        logic disk_to_nmi;
        logic disk_to_int;
        logic tc;
        logic motor;
        logic speaker_en;
    } disk_ctrl_t;

    // System control commands, low nibble of an F8 write
    typedef enum logic [3:0] {
        CMD_TERMINATE = 4'd0,
        CMD_DISK_NMI  = 4'd2,
        CMD_DISK_INT  = 4'd3,
        CMD_DISK_OFF  = 4'd4,
        CMD_TC_SET    = 4'd5,
        CMD_TC_CLR    = 4'd6,
        CMD_MOTOR_ON  = 4'd9,
        CMD_MOTOR_OFF = 4'd10,
        CMD_SPK_ON    = 4'd11,
        CMD_SPK_OFF   = 4'd12
    } sysctl_cmd_e;

    typedef enum logic [1:0] {MEM_256K, MEM_512K, MEM_1M, MEM_2M} mem_size_e;
    typedef enum logic [1:0] {OC_1X, OC_2X, OC_4X, OC_8X} overclock_e;
    typedef enum logic [1:0] {COL_WHITE, COL_GREEN, COL_AMBER} disp_color_e;

    localparam byte_t PORT_F0 = 8'hf0;
    localparam byte_t PORT_F1 = 8'hf1;
    localparam byte_t PORT_F2 = 8'hf2;
    localparam byte_t PORT_F3 = 8'hf3;
    localparam byte_t PORT_F4 = 8'hf4;
    localparam byte_t PORT_F5 = 8'hf5;
    localparam byte_t PORT_F6 = 8'hf6;
    localparam byte_t PORT_F7 = 8'hf7;
    localparam byte_t PORT_F8 = 8'hf8;

    // Boot mapping is PCW pages 0-3, CPC locks on
    localparam byte_t RESET_F0 = 8'h80;
    localparam byte_t RESET_F1 = 8'h81;
    localparam byte_t RESET_F2 = 8'h82;
    localparam byte_t RESET_F3 = 8'h83;
    localparam byte_t RESET_F4 = 8'hf1;
    localparam byte_t RESET_F5 = 8'h00;
    localparam byte_t RESET_F6 = 8'h00;
    localparam byte_t RESET_F7 = 8'h80;

    localparam int TIMER_CLEAR_CYCLES = 32;
    localparam int MISS_W             = 4;
    localparam int PAGE_OFFSET_W      = 14;
    localparam int DPRAM_PAGES_LOG2   = 3;

    // Phase increments, 2^16 divided by 16, 8, 4 and 2
    localparam int PHASE_W = 16;
    localparam logic [PHASE_W-1:0] PHASE_INC_1X = 16'h1000;
    localparam logic [PHASE_W-1:0] PHASE_INC_2X = 16'h2000;
    localparam logic [PHASE_W-1:0] PHASE_INC_4X = 16'h4000;
    localparam logic [PHASE_W-1:0] PHASE_INC_8X = 16'h8000;

    localparam rgb_t RGB_BLACK        = 18'b000000000000000000;
    localparam rgb_t RGB_WHITE        = 18'b111110111110111110;
    localparam rgb_t RGB_WHITE_BRIGHT = 18'b110111111111111111;
    localparam rgb_t RGB_GREEN        = 18'b000000111110000000;
    localparam rgb_t RGB_GREEN_BRIGHT = 18'b011001111111011001;
    localparam rgb_t RGB_AMBER        = 18'b000000011111111110;
    localparam rgb_t RGB_AMBER_BRIGHT = 18'b000000101100111111;

endpackage

//--- pcw_clock_gen.sv
/*
 * Fractional clock enables for the CPU and the floppy controller.
 * Each enable is the carry out of a 16-bit phase accumulator.
 */
`timescale 1ns/1ps
module pcw_clock_gen (
    input  logic                clk_sys,
    input  logic                reset,
    input  pcw_pkg::overclock_e overclock,
    output logic                cpu_ce,
    output logic                disk_ce
);
    import pcw_pkg::*;

    logic [PHASE_W-1:0] cpu_phase;
    logic [PHASE_W-1:0] disk_phase;
    logic [PHASE_W-1:0] cpu_inc;
    logic [PHASE_W-1:0] disk_inc;

    always_comb
    begin
        case (overclock)
            OC_1X:   cpu_inc = PHASE_INC_1X;
            OC_2X:   cpu_inc = PHASE_INC_2X;
            OC_4X:   cpu_inc = PHASE_INC_4X;
            default: cpu_inc = PHASE_INC_8X;
        endcase
        // Disk controller tops out at 4x
        disk_inc = (overclock == OC_8X) ? PHASE_INC_4X : cpu_inc;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            cpu_phase  <= '0;
            disk_phase <= '0;
            cpu_ce     <= 1'b0;
            disk_ce    <= 1'b0;
        end
        else
        begin
            // Carry out becomes the enable
            {cpu_ce, cpu_phase}   <= {1'b0, cpu_phase} + {1'b0, cpu_inc};
            {disk_ce, disk_phase} <= {1'b0, disk_phase} + {1'b0, disk_inc};
        end
    end

    // At 8x the disk enable stays in step with every other CPU enable
    a_disk_ce_aligned: assert property (@(posedge clk_sys) disable iff (reset)
        (overclock == OC_8X && disk_ce) |-> cpu_ce);

endmodule

//--- pcw_io_regs.sv
/*
 * I/O register file for ports F0-F8.
 * Holds the paging and video registers, decodes system control commands
 * written to F8 and returns the status byte on F8 and F4 reads.
 */
`timescale 1ns/1ps
module pcw_io_regs (
    input  logic                           clk_sys,
    input  logic                           reset,
    input  pcw_pkg::cpu_bus_t              bus,
    input  logic                           vblank,
    input  logic                           ntsc,
    input  logic                           fdc_latch,
    input  logic [pcw_pkg::MISS_W-1:0]     timer_misses,
    output pcw_pkg::byte_t                 rdata,
    output pcw_pkg::page_regs_t            pages,
    output pcw_pkg::video_ctrl_t           video,
    output pcw_pkg::disk_ctrl_t            disk,
    output logic                           mode_change
);
    import pcw_pkg::*;

    byte_t       port_sel;
    byte_t       roller_q;
    byte_t       scroll_q;
    byte_t       f7_q;
    byte_t       status;
    sysctl_cmd_e cmd;

    // Only the low address byte decodes for I/O
    assign port_sel = bus.addr[7:0];
    assign cmd      = sysctl_cmd_e'(bus.wdata[3:0]);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pages       <= '{RESET_F0, RESET_F1, RESET_F2, RESET_F3, RESET_F4};
            roller_q    <= RESET_F5;
            scroll_q    <= RESET_F6;
            f7_q        <= RESET_F7;
            disk        <= '0;
            mode_change <= 1'b0;
        end
        else
        begin
            mode_change <= 1'b0;
            if (bus.io_wr)
            begin
                case (port_sel)
                    PORT_F0: pages.f0 <= bus.wdata;
                    PORT_F1: pages.f1 <= bus.wdata;
                    PORT_F2: pages.f2 <= bus.wdata;
                    PORT_F3: pages.f3 <= bus.wdata;
                    PORT_F4: pages.f4 <= bus.wdata;
                    PORT_F5: roller_q <= bus.wdata;
                    PORT_F6: scroll_q <= bus.wdata;
                    PORT_F7: f7_q     <= bus.wdata;
                    PORT_F8:
                    begin
                        case (cmd)
                            CMD_DISK_NMI:
                            begin
                                disk.disk_to_nmi <= 1'b1;
                                disk.disk_to_int <= 1'b0;
                            end
                            // INT routing and disconnect both re-evaluate pending lines
                            CMD_DISK_INT:
                            begin
                                disk.disk_to_nmi <= 1'b0;
                                disk.disk_to_int <= 1'b1;
                                mode_change      <= 1'b1;
                            end
                            CMD_DISK_OFF:
                            begin
                                disk.disk_to_nmi <= 1'b0;
                                disk.disk_to_int <= 1'b0;
                                mode_change      <= 1'b1;
                            end
                            CMD_TC_SET:    disk.tc         <= 1'b1;
                            CMD_TC_CLR:    disk.tc         <= 1'b0;
                            CMD_MOTOR_ON:  disk.motor      <= 1'b1;
                            CMD_MOTOR_OFF: disk.motor      <= 1'b0;
                            CMD_SPK_ON:    disk.speaker_en <= 1'b1;
                            CMD_SPK_OFF:   disk.speaker_en <= 1'b0;
                            // Terminate bootstrap and unknown codes are ignored
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Video control straight from F5-F7
    assign video.roller_ptr  = roller_q;
    assign video.yscroll     = scroll_q;
    assign video.inverse     = f7_q[7];
    assign video.disable_vid = ~f7_q[6];

    // Status byte: 0, vblank, fdc latch, not ntsc, missed timer ticks
    assign status = {1'b0, vblank, fdc_latch, ~ntsc, timer_misses};

    always_comb
    begin
        rdata = 8'hff;
        if (bus.io_rd && (port_sel == PORT_F8 || port_sel == PORT_F4))
            rdata = status;
    end

    // A bus cycle is either a read or a write
    a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(bus.io_rd && bus.io_wr));

endmodule

//--- pcw_mem_map.sv
/*
 * CPU to RAM address translation.
 * Applies PCW extended paging or CPC read/write paging per 16K quarter,
 * masks pages by memory size and flags accesses above 256K.
 */
`timescale 1ns/1ps
module pcw_mem_map (
    input  pcw_pkg::cpu_bus_t   bus,
    input  pcw_pkg::page_regs_t pages,
    input  pcw_pkg::mem_size_e  mem_size,
    output pcw_pkg::ram_addr_t  ram_addr,
    output logic                sdram_sel
);
    import pcw_pkg::*;

    logic [1:0]               quarter;
    logic [PAGE_OFFSET_W-1:0] offset;
    byte_t                    page_byte;
    page_t                    size_mask;
    logic [2:0]               cpc_page;
    logic                     read_lock;

    assign quarter = bus.addr[CPU_ADDR_W-1 -: 2];
    assign offset  = bus.addr[PAGE_OFFSET_W-1:0];

    always_comb
    begin
        case (quarter)
            2'd0:    page_byte = pages.f0;
            2'd1:    page_byte = pages.f1;
            2'd2:    page_byte = pages.f2;
            default: page_byte = pages.f3;
        endcase
        // Lock bits for quarters 0-3 live in F4 bits 4-7
        read_lock = pages.f4[4 + quarter];
    end

    // Usable page bits grow with installed memory
    always_comb
    begin
        case (mem_size)
            MEM_256K: size_mask = 7'h0f;
            MEM_512K: size_mask = 7'h1f;
            MEM_1M:   size_mask = 7'h3f;
            default:  size_mask = 7'h7f;
        endcase
    end

    // CPC writes always use the low bank, reads only when locked
    assign cpc_page = (bus.mem_wr || read_lock) ? page_byte[2:0] : page_byte[6:4];

    always_comb
    begin
        if (page_byte[7])
            ram_addr = {page_byte[PAGE_W-1:0] & size_mask, offset};
        else
            ram_addr = {4'b0, cpc_page, offset};
    end

    // Anything past the on-chip 256K goes to SDRAM
    assign sdram_sel = (|ram_addr[RAM_ADDR_W-1 -: DPRAM_PAGES_LOG2]) && (mem_size != MEM_256K);

    // A 256K part never maps past the on-chip RAM
    always_comb
    begin
        a_no_sdram_256k: assert final (!(mem_size == MEM_256K
            && (|ram_addr[RAM_ADDR_W-1 -: DPRAM_PAGES_LOG2])));
    end

endmodule

//--- pcw_irq_ctrl.sv
/*
 * Interrupt controller for the 300 Hz timer and the floppy interrupt.
 * Produces INT and NMI, counts missed timer ticks and clears them
 * a fixed delay after the CPU reads port F4.
 */
`timescale 1ns/1ps
module pcw_irq_ctrl (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  logic                       vid_timer,
    input  logic                       fdc_int,
    input  logic                       iff1,
    input  pcw_pkg::disk_ctrl_t        disk,
    input  logic                       mode_change,
    input  logic                       f4_read,
    output logic                       fdc_latch,
    output logic [pcw_pkg::MISS_W-1:0] timer_misses,
    output logic                       int_n,
    output logic                       nmi_n
);
    import pcw_pkg::*;

    localparam int CLR_W = $clog2(TIMER_CLEAR_CYCLES);

    logic [1:0]       timer_sr;
    logic [1:0]       fdc_sr;
    logic             timer_pe;
    logic             fdc_pe;
    logic             fdc_ne;
    logic             nmi_flag;
    logic             timer_line;
    logic             int_line;
    logic             nmi_line;
    logic             clr_busy;
    logic [CLR_W-1:0] clr_count;

    // Inputs registered once, edges taken from the registered copies
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            timer_sr <= '0;
            fdc_sr   <= '0;
        end
        else
        begin
            timer_sr <= {timer_sr[0], vid_timer};
            fdc_sr   <= {fdc_sr[0], fdc_int};
        end
    end

    assign timer_pe = timer_sr[0] & ~timer_sr[1];
    assign fdc_pe   = fdc_sr[0] & ~fdc_sr[1];
    assign fdc_ne   = ~fdc_sr[0] & fdc_sr[1];

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            fdc_latch    <= 1'b0;
            nmi_flag     <= 1'b0;
            timer_misses <= '0;
            timer_line   <= 1'b0;
            int_line     <= 1'b0;
            nmi_line     <= 1'b0;
            clr_busy     <= 1'b0;
            clr_count    <= '0;
        end
        else
        begin
            // Floppy status latch follows fdc level changes
            if (fdc_pe)
            begin
                fdc_latch <= 1'b1;
                if (disk.disk_to_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_ne)
                fdc_latch <= 1'b0;

            // Lines are sampled on each timer tick
            if (timer_pe)
            begin
                if (timer_misses != '1)
                    timer_misses <= timer_misses + 1'b1;
                timer_line <= iff1;
                nmi_line   <= nmi_flag;
                int_line   <= disk.disk_to_int & fdc_latch & iff1;
            end

            // Re-route of the disk interrupt drops the stale request
            if (mode_change)
            begin
                if (disk.disk_to_nmi)
                    int_line <= 1'b0;
                else if (disk.disk_to_int)
                    nmi_flag <= 1'b0;
                else
                begin
                    int_line <= 1'b0;
                    nmi_flag <= 1'b0;
                end
            end

            // Delayed acknowledge, a new F4 read restarts the count
            if (f4_read)
            begin
                clr_busy  <= 1'b1;
                clr_count <= '0;
            end
            else if (clr_busy)
            begin
                if (clr_count == CLR_W'(TIMER_CLEAR_CYCLES - 1))
                begin
                    clr_busy     <= 1'b0;
                    timer_line   <= 1'b0;
                    timer_misses <= '0;
                end
                else
                    clr_count <= clr_count + 1'b1;
            end
        end
    end

    assign nmi_n = ~nmi_line;
    // INT held off while NMI is pending
    assign int_n = nmi_line ? 1'b1 : ~(int_line | timer_line);

    // Miss count saturates, only a pending delayed clear takes it off 15
    a_miss_saturate: assert property (@(posedge clk_sys) disable iff (reset)
        (timer_misses == '1 && !clr_busy) |=> (timer_misses == '1));

endmodule

//--- pcw_palette.sv
/*
 * Monochrome palette for the PCW display.
 * Index 0 is black, index 8 bright, all others the normal tone
 * of the selected white, green or amber phosphor.
 */
`timescale 1ns/1ps
module pcw_palette (
    input  logic [3:0]           rgbi,
    input  pcw_pkg::disp_color_e disp_color,
    output pcw_pkg::rgb_t        rgb
);
    import pcw_pkg::*;

    rgb_t normal;
    rgb_t bright;

    always_comb
    begin
        case (disp_color)
            COL_GREEN:
            begin
                normal = RGB_GREEN;
                bright = RGB_GREEN_BRIGHT;
            end
            COL_AMBER:
            begin
                normal = RGB_AMBER;
                bright = RGB_AMBER_BRIGHT;
            end
            // Code 3 falls back to white
            default:
            begin
                normal = RGB_WHITE;
                bright = RGB_WHITE_BRIGHT;
            end
        endcase

        if (rgbi == 4'd0)
            rgb = RGB_BLACK;
        else if (rgbi == 4'd8)
            rgb = bright;
        else
            rgb = normal;
    end

endmodule

//--- pcw_sysctl.sv
/*
 * Top level of the PCW system-control block.
 * Connects the I/O registers, memory mapper, interrupt controller,
 * clock enables and palette to a single-cycle CPU bus.
 */
`timescale 1ns/1ps
module pcw_sysctl (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  pcw_pkg::cpu_bus_t     bus,
    input  pcw_pkg::overclock_e   overclock,
    input  pcw_pkg::mem_size_e    mem_size,
    input  pcw_pkg::disp_color_e  disp_color,
    input  logic [3:0]            rgbi,
    input  logic                  vblank,
    input  logic                  ntsc,
    input  logic                  vid_timer,
    input  logic                  fdc_int,
    input  logic                  iff1,
    output pcw_pkg::byte_t        rdata,
    output pcw_pkg::ram_addr_t    ram_addr,
    output logic                  sdram_sel,
    output pcw_pkg::video_ctrl_t  video,
    output pcw_pkg::disk_ctrl_t   disk,
    output logic                  int_n,
    output logic                  nmi_n,
    output logic                  cpu_ce,
    output logic                  disk_ce,
    output pcw_pkg::rgb_t         rgb
);
    import pcw_pkg::*;

    page_regs_t        pages;
    logic              mode_change;
    logic              fdc_latch;
    logic [MISS_W-1:0] timer_misses;
    logic              f4_read;

    // F4 read acknowledges the timer
    assign f4_read = bus.io_rd && (bus.addr[7:0] == PORT_F4);

    pcw_io_regs u_io_regs (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .bus          (bus),
        .vblank       (vblank),
        .ntsc         (ntsc),
        .fdc_latch    (fdc_latch),
        .timer_misses (timer_misses),
        .rdata        (rdata),
        .pages        (pages),
        .video        (video),
        .disk         (disk),
        .mode_change  (mode_change)
    );

    pcw_mem_map u_mem_map (
        .bus       (bus),
        .pages     (pages),
        .mem_size  (mem_size),
        .ram_addr  (ram_addr),
        .sdram_sel (sdram_sel)
    );

    pcw_irq_ctrl u_irq_ctrl (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .vid_timer    (vid_timer),
        .fdc_int      (fdc_int),
        .iff1         (iff1),
        .disk         (disk),
        .mode_change  (mode_change),
        .f4_read      (f4_read),
        .fdc_latch    (fdc_latch),
        .timer_misses (timer_misses),
        .int_n        (int_n),
        .nmi_n        (nmi_n)
    );

    pcw_clock_gen u_clock_gen (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .overclock (overclock),
        .cpu_ce    (cpu_ce),
        .disk_ce   (disk_ce)
    );

    pcw_palette u_palette (
        .rgbi       (rgbi),
        .disp_color (disp_color),
        .rgb        (rgb)
    );

endmodule

//--- tb_pcw_sysctl.sv
/*
 * Self-checking testbench for the PCW system-control block.
 * Replays pcw_sysctl_cases.txt, one bus operation or stimulus per line,
 * and compares the DUT outputs with the expected column of each line.
 */
`timescale 1ns/1ps
module tb_pcw_sysctl;
    import pcw_pkg::*;

    localparam CASE_FILE = "pcw_sysctl_cases.txt";
    localparam int CYCLES_PER_LINE = 100;
    localparam int BASE_CYCLES     = 1000;

    logic        clk_sys;
    logic        reset;
    cpu_bus_t    bus;
    overclock_e  overclock;
    mem_size_e   mem_size;
    disp_color_e disp_color;
    logic [3:0]  rgbi;
    logic        vblank;
    logic        ntsc;
    logic        vid_timer;
    logic        fdc_int;
    logic        iff1;

    byte_t       rdata;
    ram_addr_t   ram_addr;
    logic        sdram_sel;
    video_ctrl_t video;
    disk_ctrl_t  disk;
    logic        int_n;
    logic        nmi_n;
    logic        cpu_ce;
    logic        disk_ce;
    rgb_t        rgb;

    int errors       = 0;
    int checks       = 0;
    int limit_cycles = 0;

    pcw_sysctl u_pcw_sysctl (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .bus        (bus),
        .overclock  (overclock),
        .mem_size   (mem_size),
        .disp_color (disp_color),
        .rgbi       (rgbi),
        .vblank     (vblank),
        .ntsc       (ntsc),
        .vid_timer  (vid_timer),
        .fdc_int    (fdc_int),
        .iff1       (iff1),
        .rdata      (rdata),
        .ram_addr   (ram_addr),
        .sdram_sel  (sdram_sel),
        .video      (video),
        .disk       (disk),
        .int_n      (int_n),
        .nmi_n      (nmi_n),
        .cpu_ce     (cpu_ce),
        .disk_ce    (disk_ce),
        .rgb        (rgb)
    );

    // 20 ns system clock
    initial
    begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_ram_addr(input string name, input ram_addr_t expected,
                                  input ram_addr_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Line pair is {int_n, nmi_n}
    task automatic check_lines(input string name, input logic [1:0] expected,
                               input logic [1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_video(input string name, input video_ctrl_t expected,
                               input video_ctrl_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // One-cycle I/O write, returns one cycle after the sampling edge
    task automatic io_write(input byte_t port, input byte_t data);
        @(posedge clk_sys);
        bus.addr   <= {8'h00, port};
        bus.wdata  <= data;
        bus.io_wr  <= 1'b1;
        bus.io_rd  <= 1'b0;
        bus.mem_wr <= 1'b0;
        @(posedge clk_sys);
        bus.io_wr <= 1'b0;
        @(negedge clk_sys);
    endtask

    // Read data is combinational, taken mid-cycle
    task automatic io_read(input byte_t port, output byte_t value);
        @(posedge clk_sys);
        bus.addr   <= {8'h00, port};
        bus.io_rd  <= 1'b1;
        bus.io_wr  <= 1'b0;
        bus.mem_wr <= 1'b0;
        @(negedge clk_sys);
        value = rdata;
        @(posedge clk_sys);
        bus.io_rd <= 1'b0;
    endtask

    task automatic mem_access(input cpu_addr_t addr, input mem_size_e size, input logic wr);
        @(posedge clk_sys);
        bus.addr   <= addr;
        bus.mem_wr <= wr;
        mem_size   <= size;
        @(negedge clk_sys);
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    // Each pulse gives the two-stage edge detector room on both edges
    task automatic timer_pulses(input int count);
        repeat (count)
        begin
            @(posedge clk_sys);
            vid_timer <= 1'b1;
            repeat (4) @(posedge clk_sys);
            vid_timer <= 1'b0;
            repeat (3) @(posedge clk_sys);
        end
        @(negedge clk_sys);
    endtask

    task automatic drive_fdc(input logic level);
        @(posedge clk_sys);
        fdc_int <= level;
        wait_cycles(4);
    endtask

    task automatic drive_iff1(input logic level);
        @(posedge clk_sys);
        iff1 <= level;
        wait_cycles(1);
    endtask

    task automatic show_palette(input disp_color_e color, input logic [3:0] index);
        @(posedge clk_sys);
        disp_color <= color;
        rgbi       <= index;
        @(negedge clk_sys);
    endtask

    // Video control from F5-F7, then the vblank and ntsc bits of the status byte
    task automatic video_status_checks();
        byte_t value;
        @(negedge clk_sys);
        // Roller, scroll, inverse, disable
        check_video("video after reset", {8'h00, 8'h00, 1'b1, 1'b1}, video);
        io_write(PORT_F5, 8'ha5);
        io_write(PORT_F6, 8'h3c);
        io_write(PORT_F7, 8'h40);
        check_video("video after F5-F7 writes", {8'ha5, 8'h3c, 1'b0, 1'b0}, video);
        // vblank sets bit 6, ntsc clears bit 4
        @(posedge clk_sys);
        vblank <= 1'b1;
        ntsc   <= 1'b1;
        io_read(PORT_F8, value);
        check_byte("status with vblank and ntsc", 8'h40, value);
        @(posedge clk_sys);
        vblank <= 1'b0;
        ntsc   <= 1'b0;
        @(negedge clk_sys);
    endtask

    // Accumulators restart from zero phase, then 256 cycles are counted
    task automatic count_enables(input overclock_e oc, output int cpu_n, output int disk_n);
        cpu_n  = 0;
        disk_n = 0;
        @(posedge clk_sys);
        overclock <= oc;
        reset     <= 1'b1;
        repeat (2) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (2) @(posedge clk_sys);
        repeat (256)
        begin
            @(negedge clk_sys);
            if (cpu_ce)
                cpu_n++;
            if (disk_ce)
                disk_n++;
        end
    endtask

    task automatic replay_cases(input int fd);
        logic [7:0]       op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*256-1:0] rest;
        int               code;
        int               case_no;
        int               cpu_n;
        int               disk_n;
        string            name;
        byte_t            value;
        case_no = 0;
        code = $fscanf(fd, " %c", op);
        while (code == 1)
        begin
            if (op == "#")
                code = $fgets(rest, fd);
            else
            begin
                case_no++;
                code = $fscanf(fd, "%h %h %h", a, b, c);
                name = $sformatf("case %0d %c %0h %0h", case_no, op, a, b);
                if (code != 3)
                begin
                    errors++;
                    $display("Case %0d does not hold three hex fields", case_no);
                end
                else
                begin
                    case (op)
                        "W":
                        begin
                            io_write(a[7:0], b[7:0]);
                            check_byte(name, c[7:0], {3'b000, disk});
                        end
                        "R":
                        begin
                            io_read(a[7:0], value);
                            check_byte(name, c[7:0], value);
                        end
                        // Size in the high digit, write flag in the low one
                        "M":
                        begin
                            mem_access(a[15:0], mem_size_e'(b[5:4]), b[0]);
                            check_ram_addr(name, c[20:0], ram_addr);
                            check_byte(name, {7'b0, c[21]}, {7'b0, sdram_sel});
                        end
                        "T":
                        begin
                            timer_pulses(a);
                            check_lines(name, c[1:0], {int_n, nmi_n});
                        end
                        "F":
                        begin
                            drive_fdc(a[0]);
                            check_lines(name, c[1:0], {int_n, nmi_n});
                        end
                        "I":
                        begin
                            drive_iff1(a[0]);
                            check_lines(name, c[1:0], {int_n, nmi_n});
                        end
                        "N":
                        begin
                            wait_cycles(a);
                            check_lines(name, c[1:0], {int_n, nmi_n});
                        end
                        "P":
                        begin
                            show_palette(disp_color_e'(a[1:0]), b[3:0]);
                            check_rgb(name, c[17:0], rgb);
                        end
                        "C":
                        begin
                            count_enables(overclock_e'(a[1:0]), cpu_n, disk_n);
                            check_byte({name, " cpu_ce"}, c[15:8], cpu_n[7:0]);
                            check_byte({name, " disk_ce"}, c[7:0], disk_n[7:0]);
                        end
                        default:
                        begin
                            errors++;
                            $display("Case %0d has an unknown opcode %c", case_no, op);
                        end
                    endcase
                end
            end
            code = $fscanf(fd, " %c", op);
        end
    endtask

    initial
    begin
        int               fd;
        int               line_count;
        logic [8*256-1:0] text;
        line_count = 0;
        reset      = 1'b1;
        bus        = '0;
        overclock  = OC_1X;
        mem_size   = MEM_2M;
        disp_color = COL_WHITE;
        rgbi       = 4'd0;
        vblank     = 1'b0;
        ntsc       = 1'b0;
        vid_timer  = 1'b0;
        fdc_int    = 1'b0;
        iff1       = 1'b0;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            errors++;
            $display("The case file %s could not be opened", CASE_FILE);
        end
        else
        begin
            // Run length scales with the number of case lines
            while ($fgets(text, fd) != 0)
                line_count++;
            $fclose(fd);
            limit_cycles = line_count * CYCLES_PER_LINE + BASE_CYCLES;
            fd = $fopen(CASE_FILE, "r");
            repeat (10) @(posedge clk_sys);
            reset <= 1'b0;
            video_status_checks();
            replay_cases(fd);
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_sys);
        $display("Timeout after %0d cycles, the case file did not finish", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- pcw_sysctl_cases.txt
# op a b expected, hex; W port data disk | R port 0 rdata | M addr size_wr {sdram,ram_addr}
# T pulses 0 {int_n,nmi_n} | F/I level | N cycles | P colour index rgb | C overclock 0 {cpu,disk}
# Reset mapping and a page write
M 4000 30 004000
W f1 85 00
M 4000 30 014000
# Disk control commands
W f8 09 02
W f8 0b 03
W f8 05 07
W f8 0a 05
W f8 0c 04
W f8 06 00
# PCW paging under each memory size
W f1 ff 00
M 4123 00 03c123
M 4123 10 27c123
M 4123 20 2fc123
M 4123 30 3fc123
# CPC paging with the quarter 2 lock clear
W f2 35 00
W f4 00 00
M 8010 30 00c010
M 8010 31 014010
# Timer ticks and the miss counter
R f8 0 10
T 1 0 3
R f8 0 11
I 1 0 3
T 1 0 1
R f8 0 12
T 10 0 1
R f8 0 1f
R f4 0 1f
N 28 0 3
R f8 0 10
# Floppy to NMI, disconnect, floppy to INT
W f8 02 10
F 1 0 3
T 1 0 2
R f8 0 31
W f8 04 00
T 1 0 1
W f8 03 08
T 1 0 1
R f4 0 33
N 28 0 1
F 0 0 1
I 0 0 1
T 1 0 3
R f8 0 11
# Palette
P 0 0 00000
P 0 8 37fff
P 0 5 3efbe
P 1 0 00000
P 1 8 19fd9
P 1 5 00f80
P 2 0 00000
P 2 8 00b3f
P 2 5 007fe
P 3 5 3efbe
# Clock enables over 256 cycles
C 0 0 1010
C 1 0 2020
C 2 0 4040
C 3 0 8040

//--- pcw_sysctl.f
pcw_pkg.sv
pcw_clock_gen.sv
pcw_io_regs.sv
pcw_mem_map.sv
pcw_irq_ctrl.sv
pcw_palette.sv
pcw_sysctl.sv
tb_pcw_sysctl.sv

//--- Bender.yml
package:
  name: pcw_sysctl

sources:
  # RTL in compile order, package first
  - pcw_pkg.sv
  - pcw_clock_gen.sv
  - pcw_io_regs.sv
  - pcw_mem_map.sv
  - pcw_irq_ctrl.sv
  - pcw_palette.sv
  - pcw_sysctl.sv
  - target: simulation
    files:
      - tb_pcw_sysctl.sv
